// ==== common/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// Pixel and row geometry
`define CONV_PIXEL_BITS 8
`define CONV_ROW_PIXELS 8
`define CONV_ROWS 8

// Kernel storage
`define CONV_TAPS 9
`define CONV_KERNELS 4
`define CONV_WEIGHT_WORDS 5   // 64-bit words, enough for four 72-bit kernels

// Datapath
`define CONV_LANES 8
`define CONV_PRODUCT_BITS 16

// Compute cycles spent on each kernel
`define CONV_KERNEL_CYCLES 8

`endif

// ==== common/convPkg.sv ====
`include "conv_defines.svh"

package convPkg;

	typedef logic [`CONV_PIXEL_BITS-1:0] pixel_t;

	// Pixel 0 sits in the low byte
	typedef logic [`CONV_ROW_PIXELS*`CONV_PIXEL_BITS-1:0] rowWord_t;

	// Three oldest rows, rowA in the low bits
	typedef struct packed {
		rowWord_t rowC;
		rowWord_t rowB;
		rowWord_t rowA;
	} rowTriple_t;

	typedef logic [`CONV_TAPS*`CONV_PIXEL_BITS-1:0] kernel_t;   // Tap j in byte j

	typedef logic [`CONV_TAPS*`CONV_PRODUCT_BITS-1:0] laneProducts_t;

	typedef laneProducts_t [`CONV_LANES-1:0] allProducts_t;   // Lane k at bits 144k up

	typedef enum logic [1:0] {
		stWait,
		stCompute,
		stFinish
	} convState_e;

	// Level coded command from the host
	typedef enum logic [1:0] {
		cmdEnd = 2'd0,
		cmdStart = 2'd1,
		cmdHold = 2'd2
	} ctrlCmd_e;

endpackage

// ==== windowLane/windowLane.sv ====
`timescale 1ns/10ps
`include "conv_defines.svh"

module windowLane #(
	parameter int laneIndex = 0
) (
	input convPkg::rowTriple_t rows,
	input convPkg::kernel_t kernel,
	output convPkg::laneProducts_t laneProducts
);
	import convPkg::*;

	localparam int kernelDim = 3;
	localparam int pixelBits = `CONV_PIXEL_BITS;
	localparam int productBits = `CONV_PRODUCT_BITS;

	pixel_t [`CONV_TAPS-1:0] window;

	// Columns wrap past the row end for the last lanes
	for (genvar c = 0; c < kernelDim; c++) begin : gCol
		localparam int col = (laneIndex + c) % `CONV_ROW_PIXELS;
		assign window[c] = rows.rowA[col*pixelBits +: pixelBits];
		assign window[kernelDim + c] = rows.rowB[col*pixelBits +: pixelBits];
		assign window[2*kernelDim + c] = rows.rowC[col*pixelBits +: pixelBits];
	end

	for (genvar j = 0; j < `CONV_TAPS; j++) begin : gTap
		assign laneProducts[j*productBits +: productBits] =
			kernel[j*pixelBits +: pixelBits] * window[j];   // Unsigned 8x8
	end

endmodule

// ==== source/convControl.sv ====
`timescale 1ns/10ps
`include "conv_defines.svh"

module convControl (
	input logic clk,
	input logic rst,
	input convPkg::ctrlCmd_e ctrl,
	output convPkg::convState_e state,
	output logic [$clog2(`CONV_KERNELS)-1:0] kernelIndex,
	output logic clearWeights,
	output logic finish
);
	import convPkg::*;

	localparam int cycleBits = $clog2(`CONV_KERNEL_CYCLES);

	convState_e nextState;
	logic [cycleBits-1:0] cycleCount;   // Compute cycles on the current kernel

	always_comb begin
		nextState = state;
		case (state)
			stWait: begin
				if (ctrl == cmdStart) begin
					nextState = stCompute;
				end else if (ctrl == cmdEnd) begin
					nextState = stFinish;
				end
			end
			stCompute: begin
				if (ctrl == cmdHold) begin
					nextState = stWait;
				end else if (ctrl == cmdEnd) begin
					nextState = stFinish;
				end
			end
			default: nextState = stFinish;   // Parked until reset
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= stWait;
		end else begin
			state <= nextState;
		end
	end

	// Hold leaves compute and wipes the kernel data
	assign clearWeights = (state == stCompute) && (ctrl == cmdHold);
	assign finish = (state == stFinish);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cycleCount <= '0;
			kernelIndex <= '0;
		end else if (clearWeights) begin
			cycleCount <= '0;
			kernelIndex <= '0;
		end else if (state == stCompute) begin
			if (cycleCount == cycleBits'(`CONV_KERNEL_CYCLES - 1)) begin
				cycleCount <= '0;
				if (kernelIndex == ($bits(kernelIndex))'(`CONV_KERNELS - 1)) begin
					kernelIndex <= '0;
				end else begin
					kernelIndex <= kernelIndex + 1'b1;
				end
			end else begin
				cycleCount <= cycleCount + 1'b1;
			end
		end
	end

	stateLegal: assert property (@(posedge clk) disable iff (rst)
		state inside {stWait, stCompute, stFinish});

	// Hold only matters while computing
	holdInWait: assert property (@(posedge clk) disable iff (rst)
		(state == stWait && ctrl == cmdHold) |=> state == stWait);

endmodule

// ==== source/rowBuffer.sv ====
`timescale 1ns/10ps
`include "conv_defines.svh"

module rowBuffer (
	input logic clk,
	input logic rst,
	input convPkg::convState_e state,
	input convPkg::rowWord_t rowData,
	input logic rowValid,
	output convPkg::rowTriple_t rows
);
	import convPkg::*;

	rowWord_t rowReg [`CONV_ROWS];   // Index 0 holds the oldest row

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `CONV_ROWS; i++) begin
				rowReg[i] <= '0;
			end
		end else if (state == stWait && rowValid) begin
			// Oldest row drops out
			for (int i = 0; i < `CONV_ROWS - 1; i++) begin
				rowReg[i] <= rowReg[i + 1];
			end
			rowReg[`CONV_ROWS - 1] <= rowData;
		end else if (state == stCompute) begin
			for (int i = 0; i < `CONV_ROWS - 1; i++) begin
				rowReg[i] <= rowReg[i + 1];
			end
			rowReg[`CONV_ROWS - 1] <= rowReg[0];   // Oldest wraps round to newest
		end
	end

	assign rows.rowA = rowReg[0];
	assign rows.rowB = rowReg[1];
	assign rows.rowC = rowReg[2];

endmodule

// ==== source/kernelStore.sv ====
`timescale 1ns/10ps
`include "conv_defines.svh"

module kernelStore (
	input logic clk,
	input logic rst,
	input convPkg::convState_e state,
	input logic [`CONV_ROW_PIXELS*`CONV_PIXEL_BITS-1:0] weightData,
	input logic weightValid,
	input logic rowValid,
	input logic clearWeights,
	input logic [$clog2(`CONV_KERNELS)-1:0] kernelIndex,
	output convPkg::kernel_t kernel
);
	import convPkg::*;

	localparam int wordBits = `CONV_ROW_PIXELS * `CONV_PIXEL_BITS;
	localparam int countBits = $clog2(`CONV_WEIGHT_WORDS + 1);

	logic [`CONV_WEIGHT_WORDS*wordBits-1:0] weightReg;
	logic [countBits-1:0] writeCount;
	logic weightWrite;

	// A row in the same cycle takes priority and the word is dropped
	assign weightWrite = (state == stWait) && weightValid && !rowValid
		&& (writeCount < countBits'(`CONV_WEIGHT_WORDS));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			weightReg <= '0;
			writeCount <= '0;
		end else if (clearWeights) begin
			weightReg <= '0;
			writeCount <= '0;
		end else if (weightWrite) begin
			weightReg[writeCount*wordBits +: wordBits] <= weightData;
			writeCount <= writeCount + 1'b1;
		end
	end

	// Kernels are packed back to back, 72 bits each
	assign kernel = weightReg[kernelIndex*$bits(kernel_t) +: $bits(kernel_t)];

	storeFull: assert property (@(posedge clk) disable iff (rst)
		(writeCount == countBits'(`CONV_WEIGHT_WORDS) && !clearWeights)
		|=> $stable(weightReg));

endmodule

// ==== source/productCollector.sv ====
`timescale 1ns/10ps

module productCollector (
	input logic clk,
	input logic rst,
	input convPkg::convState_e state,
	input convPkg::allProducts_t laneIn,
	output convPkg::allProducts_t products,
	output logic resValid
);
	import convPkg::*;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			products <= '0;
			resValid <= 1'b0;
		end else begin
			resValid <= (state == stCompute);
			// Last results stay visible outside compute
			if (state == stCompute) begin
				products <= laneIn;
			end
		end
	end

endmodule

// ==== source/convEngine.sv ====
`timescale 1ns/10ps
`include "conv_defines.svh"

module convEngine (
	input logic clk,
	input logic rst,
	input convPkg::ctrlCmd_e ctrl,
	input convPkg::rowWord_t rowData,
	input logic rowValid,
	input logic [`CONV_ROW_PIXELS*`CONV_PIXEL_BITS-1:0] weightData,
	input logic weightValid,
	output convPkg::allProducts_t products,
	output logic resValid,
	output logic finish
);
	import convPkg::*;

	convState_e state;
	logic [$clog2(`CONV_KERNELS)-1:0] kernelIndex;
	logic clearWeights;
	rowTriple_t rows;
	kernel_t kernel;
	allProducts_t laneAll;   // Unregistered lane outputs

	convControl u_convControl (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.state(state),
		.kernelIndex(kernelIndex),
		.clearWeights(clearWeights),
		.finish(finish)
	);

	rowBuffer u_rowBuffer (
		.clk(clk),
		.rst(rst),
		.state(state),
		.rowData(rowData),
		.rowValid(rowValid),
		.rows(rows)
	);

	kernelStore u_kernelStore (
		.clk(clk),
		.rst(rst),
		.state(state),
		.weightData(weightData),
		.weightValid(weightValid),
		.rowValid(rowValid),
		.clearWeights(clearWeights),
		.kernelIndex(kernelIndex),
		.kernel(kernel)
	);

	// One lane per output column, all sharing rows and kernel
	for (genvar k = 0; k < `CONV_LANES; k++) begin : gLane
		windowLane #(.laneIndex(k)) u_windowLane (
			.rows(rows),
			.kernel(kernel),
			.laneProducts(laneAll[k])
		);
	end

	productCollector u_productCollector (
		.clk(clk),
		.rst(rst),
		.state(state),
		.laneIn(laneAll),
		.products(products),
		.resValid(resValid)
	);

endmodule

// ==== dv/convEngineTb.sv ====
`timescale 1ns/10ps
`include "conv_defines.svh"

module convEngineTb;
	import convPkg::*;

	localparam int wordBits = `CONV_ROW_PIXELS * `CONV_PIXEL_BITS;
	localparam int storeBits = `CONV_WEIGHT_WORDS * wordBits;
	localparam int timeoutCycles = 20;

	logic clk;
	logic rst;
	ctrlCmd_e ctrl;
	rowWord_t rowData;
	logic rowValid;
	logic [wordBits-1:0] weightData;
	logic weightValid;
	allProducts_t products;
	logic resValid;
	logic finish;

	// Model of the engine, updated on the same edges as the DUT
	rowWord_t mRows [`CONV_ROWS];   // Index 0 is the oldest row
	logic [storeBits-1:0] mWeights;
	int mCount;
	int mCycle;
	int mKidx;
	convState_e mState;
	allProducts_t expProducts;
	logic expResValid;

	convEngine u_convEngine (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.rowData(rowData),
		.rowValid(rowValid),
		.weightData(weightData),
		.weightValid(weightValid),
		.products(products),
		.resValid(resValid),
		.finish(finish)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Expected lane products for one set of rows and one kernel
	function automatic allProducts_t refProducts(input rowWord_t rA, input rowWord_t rB,
			input rowWord_t rC, input logic [storeBits-1:0] w, input int kidx);
		allProducts_t res;
		kernel_t kern;
		pixel_t pix;
		int col;
		kern = w[kidx*`CONV_TAPS*`CONV_PIXEL_BITS +: `CONV_TAPS*`CONV_PIXEL_BITS];
		res = '0;
		for (int lane = 0; lane < `CONV_LANES; lane++) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				col = (lane + t % 3) % `CONV_ROW_PIXELS;   // Wraps for lanes 6 and 7
				case (t / 3)
					0: pix = rA[col*8 +: 8];
					1: pix = rB[col*8 +: 8];
					default: pix = rC[col*8 +: 8];
				endcase
				res[lane][t*16 +: 16] = 16'(kern[t*8 +: 8]) * 16'(pix);
			end
		end
		return res;
	endfunction

	function automatic rowWord_t randomWord();
		return {$urandom, $urandom};
	endfunction

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `CONV_ROWS; i++) begin
				mRows[i] <= '0;
			end
			mWeights <= '0;
			mCount <= 0;
			mCycle <= 0;
			mKidx <= 0;
			mState <= stWait;
			expProducts <= '0;
			expResValid <= 1'b0;
		end else begin
			expResValid <= (mState == stCompute);
			if (mState == stCompute) begin
				expProducts <= refProducts(mRows[0], mRows[1], mRows[2], mWeights, mKidx);
			end
			case (mState)
				stWait: begin
					if (rowValid) begin   // Row beats a weight word in the same cycle
						for (int i = 0; i < `CONV_ROWS - 1; i++) begin
							mRows[i] <= mRows[i + 1];
						end
						mRows[`CONV_ROWS - 1] <= rowData;
					end else if (weightValid && mCount < `CONV_WEIGHT_WORDS) begin
						mWeights[mCount*wordBits +: wordBits] <= weightData;
						mCount <= mCount + 1;
					end
					if (ctrl == cmdStart) begin
						mState <= stCompute;
					end else if (ctrl == cmdEnd) begin
						mState <= stFinish;
					end
				end
				stCompute: begin
					for (int i = 0; i < `CONV_ROWS - 1; i++) begin
						mRows[i] <= mRows[i + 1];
					end
					mRows[`CONV_ROWS - 1] <= mRows[0];
					if (ctrl == cmdHold) begin
						mState <= stWait;
						mWeights <= '0;
						mCount <= 0;
						mCycle <= 0;
						mKidx <= 0;
					end else begin
						if (ctrl == cmdEnd) begin
							mState <= stFinish;
						end
						if (mCycle == `CONV_KERNEL_CYCLES - 1) begin
							mCycle <= 0;
							mKidx <= (mKidx + 1) % `CONV_KERNELS;
						end else begin
							mCycle <= mCycle + 1;
						end
					end
				end
				default: ;   // Parked
			endcase
		end
	end

	task automatic checkValue(input string name, input logic [1151:0] actual,
			input logic [1151:0] expected);
		if (actual !== expected) begin
			$display("error: time %0t signal %s expected %h actual %h", $time, name,
				expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			checkValue("products", products, expProducts);
			checkValue("resValid", resValid, expResValid);
			checkValue("finish", finish, mState == stFinish);
		end
	end

	task automatic waitResValid(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (resValid !== level) begin
			if (cycles == timeoutCycles) begin
				$display("*** TEST FAILED ***");
				$fatal(1, "resValid did not reach %0b in time", level);
			end else begin
				cycles++;
				@(negedge clk);
			end
		end
	endtask

	task automatic waitFinish();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (finish !== 1'b1) begin
			if (cycles == timeoutCycles) begin
				$display("*** TEST FAILED ***");
				$fatal(1, "finish was never raised after the end command");
			end else begin
				cycles++;
				@(negedge clk);
			end
		end
	endtask

	task automatic sendRow(input rowWord_t data);
		@(posedge clk);
		rowData <= data;
		rowValid <= 1'b1;
		weightValid <= 1'b0;
	endtask

	task automatic sendWeight(input logic [wordBits-1:0] data);
		@(posedge clk);
		weightData <= data;
		weightValid <= 1'b1;
		rowValid <= 1'b0;
	endtask

	task automatic setCommand(input ctrlCmd_e cmd);
		@(posedge clk);
		ctrl <= cmd;
		rowValid <= 1'b0;
		weightValid <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'hb4ee_f3d7));
		rst = 1'b1;
		ctrl = cmdHold;
		rowData = '0;
		rowValid = 1'b0;
		weightData = '0;
		weightValid = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// Idle after reset
		repeat (4) begin
			@(negedge clk);
			checkValue("resValid", resValid, 1'b0);
			checkValue("finish", finish, 1'b0);
		end

		// Full load then 40 compute cycles, five kernel periods
		for (int i = 0; i < `CONV_ROWS; i++) begin
			sendRow(randomWord());
		end
		for (int i = 0; i < `CONV_WEIGHT_WORDS; i++) begin
			sendWeight(randomWord());
		end
		setCommand(cmdStart);
		waitResValid(1'b1);
		repeat (40) @(negedge clk);

		// Hold clears weights, new rows alone give zeros
		setCommand(cmdHold);
		waitResValid(1'b0);
		for (int i = 0; i < `CONV_ROWS; i++) begin
			sendRow(randomWord());
		end
		setCommand(cmdStart);
		waitResValid(1'b1);
		repeat (8) begin
			checkValue("products", products, '0);
			@(negedge clk);
		end
		setCommand(cmdHold);
		waitResValid(1'b0);

		// Row and weight together, the word is dropped
		@(posedge clk);
		rowData <= randomWord();
		rowValid <= 1'b1;
		weightData <= randomWord();
		weightValid <= 1'b1;
		sendWeight(randomWord());
		setCommand(cmdStart);
		waitResValid(1'b1);
		repeat (16) @(negedge clk);

		// End parks the engine until reset
		setCommand(cmdEnd);
		waitFinish();
		@(negedge clk);
		checkValue("resValid", resValid, 1'b0);
		setCommand(cmdStart);
		repeat (10) begin
			@(negedge clk);
			checkValue("finish", finish, 1'b1);
			checkValue("resValid", resValid, 1'b0);
		end
		@(posedge clk);
		rst <= 1'b1;
		ctrl <= cmdHold;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(negedge clk);
		checkValue("finish", finish, 1'b0);
		checkValue("resValid", resValid, 1'b0);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+common
common/convPkg.sv
windowLane/windowLane.sv
source/convControl.sv
source/rowBuffer.sv
source/kernelStore.sv
source/productCollector.sv
source/convEngine.sv
dv/convEngineTb.sv
